/* carry_pkg.sv */
package carry_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    // One output byte of the coder
    localparam int byte_width = 8;

    // A code word is the low byte with the carry bit on top
    localparam int code_width = byte_width + 1;

    // Longest run of 0xFF bytes the holder can count
    localparam int run_max = 255;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------

    // Bit 8 is the carry, bits 7 to 0 are the low byte
    typedef logic [code_width-1:0] code_word_t;

    typedef logic [byte_width-1:0] code_byte_t;

    // Number of bytes in a run, sized to hold run_max
    typedef logic [$clog2(run_max + 1)-1:0] run_length_t;

    // --------------------------------------------------
    // Byte constants
    // --------------------------------------------------

    // A byte of this value may still be hit by a later carry
    localparam code_byte_t byte_all_ones = 8'hFF;

    // What a run byte turns into once a carry has passed through it
    localparam code_byte_t byte_zero = 8'h00;

    // --------------------------------------------------
    // Holder FSM
    // --------------------------------------------------

    typedef enum logic {
        hold_empty,
        hold_byte
    } holder_state_t;

endpackage

/* carry_holder.sv */
`timescale 1ns/1ns

module carry_holder
    import carry_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        word_valid,
    input  logic        first,
    input  logic        frame_final,
    input  code_word_t  word,
    output logic        release_valid,
    output code_byte_t  release_byte,
    output logic        release_carry,
    output run_length_t release_run,
    output logic        tail_valid,
    output code_byte_t  tail_byte,
    output logic        last
);

    holder_state_t state;
    code_byte_t    pending;
    run_length_t   run;

    holder_state_t cur_state;
    run_length_t   cur_run;
    code_byte_t    word_byte;
    logic          word_carry;
    logic          take_empty;
    logic          take_release;
    logic          take_extend;

    holder_state_t next_state;
    code_byte_t    next_pending;
    run_length_t   next_run;

    assign word_byte  = word[byte_width-1:0];
    assign word_carry = word[byte_width];

    // --------------------------------------------------
    // Word classification
    // --------------------------------------------------

    // A frame start drops whatever is held before this cycle's word is looked at
    assign cur_state = first ? hold_empty : state;
    assign cur_run   = first ? '0 : run;

    // First byte of a frame only fills the holder
    assign take_empty = word_valid && (cur_state == hold_empty);

    // A settled byte or any carry pushes the pending byte and its run out
    assign take_release = word_valid && (cur_state == hold_byte)
                          && ((word_byte != byte_all_ones) || word_carry);

    // 0xFF without carry may still change later, so it only lengthens the run
    assign take_extend = word_valid && (cur_state == hold_byte) && !take_release;

    // Holder contents after this word, before any flush
    always_comb begin
        next_state   = cur_state;
        next_pending = pending;
        next_run     = cur_run;
        if (take_empty || take_release) begin
            next_state   = hold_byte;
            next_pending = word_byte;
            next_run     = '0;
        end else if (take_extend) begin
            next_run = cur_run + 1'b1;
        end
    end

    // --------------------------------------------------
    // Release and flush
    // --------------------------------------------------

    always_comb begin
        release_valid = take_release;
        release_byte  = pending;
        release_carry = word_carry;
        release_run   = cur_run;
        tail_valid    = 1'b0;
        tail_byte     = word_byte;
        if (frame_final) begin
            if (take_release) begin
                // The new pending byte follows the released run as the tail
                tail_valid = 1'b1;
            end else if (next_state == hold_byte) begin
                // Nothing left to carry into, so the held byte goes out as it is
                release_valid = 1'b1;
                release_byte  = next_pending;
                release_carry = 1'b0;
                release_run   = next_run;
            end
        end
    end

    assign last = frame_final;

    // --------------------------------------------------
    // State
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hold_empty;
            run   <= '0;
        end else if (frame_final) begin
            state <= hold_empty;
            run   <= '0;
        end else begin
            state <= next_state;
            run   <= next_run;
        end
    end

    // Only meaningful while state is hold_byte
    always_ff @(posedge clk) begin
        pending <= next_pending;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // The coder never raises a carry before it has produced a byte of the frame
    a_carry_needs_byte: assert property (@(posedge clk) disable iff (reset)
        (word_valid && word_carry) |-> (cur_state == hold_byte));

    // A longer run than the counter holds would lose bytes
    a_run_limit: assert property (@(posedge clk) disable iff (reset)
        take_extend |-> (cur_run != run_max));

endmodule

/* stream_emitter.sv */
`timescale 1ns/1ns

module stream_emitter
    import carry_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        release_valid,
    input  code_byte_t  release_byte,
    input  logic        release_carry,
    input  run_length_t release_run,
    input  logic        tail_valid,
    input  code_byte_t  tail_byte,
    input  logic        last,
    output logic        lead_valid,
    output code_byte_t  lead_byte,
    output code_byte_t  run_byte,
    output run_length_t run_length,
    output logic        tail_valid_out,
    output code_byte_t  tail_byte_out,
    output logic        out_last
);

    code_byte_t resolved_byte;
    code_byte_t resolved_run_byte;

    // --------------------------------------------------
    // Carry resolution
    // --------------------------------------------------

    // 0xFF plus a carry wraps to 0x00, which the coder never lets spill further
    assign resolved_byte = release_byte + code_byte_t'(release_carry);

    // Every byte of the run was 0xFF, so a carry turns all of them to zero
    assign resolved_run_byte = release_carry ? byte_zero : byte_all_ones;

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            lead_valid     <= 1'b0;
            run_length     <= '0;
            tail_valid_out <= 1'b0;
            out_last       <= 1'b0;
        end else begin
            lead_valid     <= release_valid;
            run_length     <= release_valid ? release_run : '0;
            tail_valid_out <= tail_valid;
            out_last       <= last;
        end
    end

    always_ff @(posedge clk) begin
        lead_byte     <= resolved_byte;
        run_byte      <= resolved_run_byte;
        tail_byte_out <= tail_byte;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // A tail byte only closes a frame, and it always follows a lead byte
    a_tail_closes_frame: assert property (@(posedge clk) disable iff (reset)
        tail_valid_out |-> (lead_valid && out_last));

endmodule

/* carry_propagation.sv */
`timescale 1ns/1ns

module carry_propagation
    import carry_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        word_valid,
    input  code_word_t  word,
    input  logic        first,
    input  logic        frame_final,
    output logic        lead_valid,
    output code_byte_t  lead_byte,
    output code_byte_t  run_byte,
    output run_length_t run_length,
    output logic        tail_valid,
    output code_byte_t  tail_byte,
    output logic        out_last
);

    // --------------------------------------------------
    // Holder to emitter
    // --------------------------------------------------

    logic        release_valid;
    code_byte_t  release_byte;
    logic        release_carry;
    run_length_t release_run;
    logic        release_tail_valid;
    code_byte_t  release_tail_byte;
    logic        release_last;

    // Decides in the input cycle which bytes leave the holder
    carry_holder carry_holder_inst (
        .clk           (clk),
        .reset         (reset),
        .word_valid    (word_valid),
        .first         (first),
        .frame_final   (frame_final),
        .word          (word),
        .release_valid (release_valid),
        .release_byte  (release_byte),
        .release_carry (release_carry),
        .release_run   (release_run),
        .tail_valid    (release_tail_valid),
        .tail_byte     (release_tail_byte),
        .last          (release_last)
    );

    // Resolves the carry and presents the bytes one cycle later
    stream_emitter stream_emitter_inst (
        .clk            (clk),
        .reset          (reset),
        .release_valid  (release_valid),
        .release_byte   (release_byte),
        .release_carry  (release_carry),
        .release_run    (release_run),
        .tail_valid     (release_tail_valid),
        .tail_byte      (release_tail_byte),
        .last           (release_last),
        .lead_valid     (lead_valid),
        .lead_byte      (lead_byte),
        .run_byte       (run_byte),
        .run_length     (run_length),
        .tail_valid_out (tail_valid),
        .tail_byte_out  (tail_byte),
        .out_last       (out_last)
    );

endmodule

/* carry_propagation_tb.sv */
`timescale 1ns/1ns

module carry_propagation_tb
    import carry_pkg::*;
();

    localparam int directed_words = 40;
    localparam int random_frames  = 20;
    localparam int random_max_len = 40;
    // Twenty cycles per driven word plus a margin for reset and idle gaps
    localparam int cycle_limit = 20 * (directed_words + random_frames * random_max_len) + 200;

    logic        clk;
    logic        reset;
    logic        word_valid;
    code_word_t  word;
    logic        first;
    logic        frame_final;
    logic        lead_valid;
    code_byte_t  lead_byte;
    code_byte_t  run_byte;
    run_length_t run_length;
    logic        tail_valid;
    code_byte_t  tail_byte;
    logic        out_last;

    // Reference model state
    logic        m_held;
    code_byte_t  m_pending;
    run_length_t m_run;
    code_byte_t  exp_q[$];
    code_byte_t  act_q[$];

    // Output flags seen in the out_last cycle
    logic        last_seen;
    logic        last_lead_valid;
    logic        last_tail_valid;
    run_length_t last_run_length;

    string test_name;
    int    cycle_count;
    int    byte_errors;
    int    run_errors;
    int    flag_errors;
    int    other_errors;

    carry_propagation carry_propagation_inst (
        .clk         (clk),
        .reset       (reset),
        .word_valid  (word_valid),
        .word        (word),
        .first       (first),
        .frame_final (frame_final),
        .lead_valid  (lead_valid),
        .lead_byte   (lead_byte),
        .run_byte    (run_byte),
        .run_length  (run_length),
        .tail_valid  (tail_valid),
        .tail_byte   (tail_byte),
        .out_last    (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            if (lead_valid) begin
                act_q.push_back(lead_byte);
            end
            for (int i = 0; i < int'(run_length); i++) begin
                act_q.push_back(run_byte);
            end
            if (tail_valid) begin
                act_q.push_back(tail_byte);
            end
            if (out_last) begin
                last_seen       = 1'b1;
                last_lead_valid = lead_valid;
                last_tail_valid = tail_valid;
                last_run_length = run_length;
            end
        end
    end

    // --------------------------------------------------
    // Reference model and compare tasks
    // --------------------------------------------------

    task automatic model_step(input logic valid, input code_word_t w, input logic is_first,
                              input logic is_final);
        code_byte_t b;
        code_byte_t c;
        logic       released;
        b = w[7:0];
        c = code_byte_t'(w[8]);
        released = 1'b0;
        if (is_first) begin
            m_held = 1'b0;
            m_run  = '0;
        end
        if (valid) begin
            if (!m_held) begin
                m_held    = 1'b1;
                m_pending = b;
                m_run     = '0;
            end else if (b != 8'hFF || w[8]) begin
                // Carry ripples into the pending byte and flips the whole 0xFF run
                exp_q.push_back(code_byte_t'(m_pending + c));
                for (int i = 0; i < int'(m_run); i++) begin
                    exp_q.push_back(w[8] ? 8'h00 : 8'hFF);
                end
                m_pending = b;
                m_run     = '0;
                released  = 1'b1;
            end else begin
                m_run++;
            end
        end
        if (is_final) begin
            if (m_held) begin
                exp_q.push_back(m_pending);
                if (!released) begin
                    for (int i = 0; i < int'(m_run); i++) begin
                        exp_q.push_back(8'hFF);
                    end
                end
            end
            m_held = 1'b0;
            m_run  = '0;
        end
    endtask

    task automatic check_byte(input string name, input code_byte_t exp, input code_byte_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            byte_errors++;
        end
    endtask

    task automatic check_run(input string name, input run_length_t exp, input run_length_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            run_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    // --------------------------------------------------
    // Drive helpers
    // --------------------------------------------------

    task automatic begin_frame(input string name);
        test_name = name;
        exp_q.delete();
        act_q.delete();
        last_seen = 1'b0;
    endtask

    task automatic send_word(input logic valid, input code_word_t w, input logic is_first,
                             input logic is_final);
        @(posedge clk);
        #1;
        word_valid  = valid;
        word        = w;
        first       = is_first;
        frame_final = is_final;
        model_step(valid, w, is_first, is_final);
    endtask

    task automatic compare_frame();
        int n;
        @(posedge clk);
        #1;
        word_valid  = 1'b0;
        word        = '0;
        first       = 1'b0;
        frame_final = 1'b0;
        // The closing bytes sit on the outputs in exactly the cycle after the final input
        last_seen = 1'b0;
        @(posedge clk);
        if (!last_seen) begin
            $display("Test %s did not raise out_last one cycle after the final input",
                     test_name);
            other_errors++;
        end
        check_run({test_name, " byte count"}, run_length_t'(exp_q.size()),
                  run_length_t'(act_q.size()));
        n = (exp_q.size() < act_q.size()) ? exp_q.size() : act_q.size();
        for (int i = 0; i < n; i++) begin
            check_byte($sformatf("%s byte %0d", test_name, i), exp_q[i], act_q[i]);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_pass_through();
        begin_frame("pass_through");
        send_word(1'b1, 9'h012, 1'b1, 1'b0);
        send_word(1'b1, 9'h034, 1'b0, 1'b0);
        send_word(1'b1, 9'h056, 1'b0, 1'b0);
        send_word(1'b1, 9'h078, 1'b0, 1'b1);
        compare_frame();
        check_flag("pass_through tail_valid", 1'b1, last_tail_valid);
    endtask

    task automatic test_carry_add();
        begin_frame("carry_add");
        send_word(1'b1, 9'h010, 1'b1, 1'b0);
        send_word(1'b1, 9'h120, 1'b0, 1'b0);
        send_word(1'b1, 9'h1FF, 1'b0, 1'b0);
        // The pending 0xFF wraps to 0x00 under this carry
        send_word(1'b1, 9'h105, 1'b0, 1'b1);
        compare_frame();
    endtask

    task automatic test_run_release(input logic carry);
        begin_frame(carry ? "run_carry" : "run_plain");
        send_word(1'b1, 9'h040, 1'b1, 1'b0);
        repeat (3) send_word(1'b1, 9'h0FF, 1'b0, 1'b0);
        send_word(1'b1, {carry, 8'h41}, 1'b0, 1'b1);
        compare_frame();
        check_flag({test_name, " lead_valid"}, 1'b1, last_lead_valid);
    endtask

    task automatic test_flush_run(input logic with_word);
        begin_frame(with_word ? "flush_in_run" : "flush_no_word");
        send_word(1'b1, 9'h070, 1'b1, 1'b0);
        repeat (2) send_word(1'b1, 9'h0FF, 1'b0, 1'b0);
        send_word(with_word, 9'h0FF, 1'b0, 1'b1);
        compare_frame();
        check_flag({test_name, " lead_valid"}, 1'b1, last_lead_valid);
        check_flag({test_name, " tail_valid"}, 1'b0, last_tail_valid);
        check_run({test_name, " run_length"}, with_word ? 8'd3 : 8'd2, last_run_length);
    endtask

    task automatic test_first_restart();
        begin_frame("first_restart");
        send_word(1'b1, 9'h011, 1'b1, 1'b0);
        repeat (2) send_word(1'b1, 9'h0FF, 1'b0, 1'b0);
        // Held 0x11 and its run are dropped here
        send_word(1'b1, 9'h033, 1'b1, 1'b0);
        send_word(1'b1, 9'h044, 1'b0, 1'b0);
        send_word(1'b1, 9'h055, 1'b0, 1'b1);
        compare_frame();
    endtask

    task automatic test_random_frames();
        int         len;
        logic       carry;
        code_byte_t b;
        for (int f = 0; f < random_frames; f++) begin
            begin_frame($sformatf("random_%0d", f));
            len = $urandom_range(1, random_max_len);
            for (int i = 0; i < len; i++) begin
                if ($urandom_range(0, 99) < 30) begin
                    b = 8'hFF;
                end else begin
                    b = code_byte_t'($urandom_range(0, 254));
                end
                carry = (i > 0) && ($urandom_range(0, 99) < 20);
                send_word(1'b1, {carry, b}, i == 0, i == len - 1);
            end
            compare_frame();
        end
    endtask

    initial begin
        void'($urandom(32'hdb0b));
        reset       = 1'b1;
        word_valid  = 1'b0;
        word        = '0;
        first       = 1'b0;
        frame_final = 1'b0;
        m_held      = 1'b0;
        m_pending   = '0;
        m_run       = '0;
        last_seen   = 1'b0;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_pass_through();
        test_carry_add();
        test_run_release(1'b0);
        test_run_release(1'b1);
        test_flush_run(1'b1);
        test_flush_run(1'b0);
        test_first_restart();
        test_random_frames();

        $display("Errors: byte %0d, length %0d, flag %0d, other %0d",
                 byte_errors, run_errors, flag_errors, other_errors);
        if (byte_errors + run_errors + flag_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* carry_propagation.f */
carry_pkg.sv
carry_holder.sv
stream_emitter.sv
carry_propagation.sv
carry_propagation_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the carry propagation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f carry_propagation.f \
    --top-module carry_propagation_tb \
    -o carry_propagation_sim \
    && ./obj_dir/carry_propagation_sim | tee /dev/stderr \
        | grep "Simulation completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
